// ==== tests/dsp_ctrl_stimulus.txt ====
# Numbers in hex. wr addr data | wait n | status btn clk link rx tx | pps | rand_leds n
# rd word value-or-compute | led value-or-compute | ctrl clk ser adc phy_reset_n
# Reset state
rd c 00080002
rd 9 1e000000
ctrl 0 0 0 1
led 00
status 0 1 0 1 1
led 1c
led compute
status 0 0 0 0 0
# Control registers, unused slots ignored
wr 0 15
ctrl 15 0 0 1
wr 1 a
wr 2 5
wr 4 1
ctrl 15 a 5 0
wr 5 ff
wr 7 ff
wr 8 ff
ctrl 15 a 5 0
rd 9 1e00050a
wr 4 0
wr 0 ffffffe3
ctrl 3 a 5 1
# LED select with random registers and inputs
rand_leds 10
# Time load at 7 s and 45 ticks, wraps at 50
wr a 7
wr b 2d
wait 14
rd a compute
rd b compute
wr a 63
rd a compute
wait 3c
rd a compute
rd b compute
# PPS capture with the link up
wr 6 2
wr 3 0
status 0 0 1 0 0
led 00
pps
rd e compute
rd f compute
led 02
led compute
# Misc status bits 13, 11 and 10
status 1 0 0 0 0
rd d 00002000
status 0 1 0 0 0
rd d 00000800
status 0 0 1 0 0
rd d 00000400
status 1 1 1 0 0
rd d 00002c00

// ==== filelist.f ====
common/dsp_ctrl_pkg.sv
hw/board_ctrl_regs.sv
hw/vita_time/vita_timekeeper.sv
hw/vita_time/pps_capture.sv
hw/status_readback.sv
hw/dsp_ctrl_core.sv
tests/tb_dsp_ctrl_core.sv

// ==== Makefile ====
# Verilator build and run of the DSP control slice testbench
# Run from the project root so the stimulus file path resolves

VERILATOR ?= verilator
TOP       ?= tb_dsp_ctrl_core
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f filelist.f --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	mkdir -p $(dir $(LOG))
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
	rm -f $(LOG)

// ==== tests/tb_dsp_ctrl_core.sv ====
////////////////////////////////////////
// Testbench for dsp_ctrl_core, run from the project root
// Commands and expected values come from the stimulus file
// Time checks assume 50 ticks per second
////////////////////////////////////////

module tb_dsp_ctrl_core
   import dsp_ctrl_pkg::*;
();

   localparam int TB_TICKS  = 50;
   localparam     STIM_FILE = "tests/dsp_ctrl_stimulus.txt";

   logic      dsp_clk = 1'b0;
   logic      por_rst;
   logic      set_stb_i;
   set_addr_t set_addr_i;
   set_data_t set_data_i;
   rb_addr_t  rb_addr_i;
   rb_word_t  rb_data_o;
   logic      pps_i;
   logic      pps_int_o;
   logic      clk_status_i;
   logic      button_i;
   logic      serdes_link_up_i;
   logic      run_rx_i;
   logic      run_tx_i;
   led_t      leds_o;
   clk_ctrl_t clock_ctrl_o;
   ctrl_nib_t serdes_ctrl_o;
   ctrl_nib_t adc_ctrl_o;
   logic      phy_reset_n_o;

   // Reference state kept from the writes seen so far
   int          cycle_count = 0;
   int          limit_cycles = 0;
   int          load_edge;          // Edge that last loaded the time
   seconds_t    held_secs;
   seconds_t    base_secs;
   ticks_t      base_ticks;
   vita_time_t  pps_time;
   led_t        led_sw;
   led_t        led_src;
   logic        good_sync;
   logic [31:0] lcg_state = 32'd74;

   dsp_ctrl_core #(.TICKS_PER_SEC(ticks_t'(TB_TICKS))) uut (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .rb_addr_i(rb_addr_i), .rb_data_o(rb_data_o),
      .pps_i(pps_i), .pps_int_o(pps_int_o),
      .clk_status_i(clk_status_i), .button_i(button_i),
      .serdes_link_up_i(serdes_link_up_i), .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .leds_o(leds_o), .clock_ctrl_o(clock_ctrl_o), .serdes_ctrl_o(serdes_ctrl_o),
      .adc_ctrl_o(adc_ctrl_o), .phy_reset_n_o(phy_reset_n_o));

   always #4 dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) cycle_count <= cycle_count + 1;

   ////////////////////////////////////////
   // Failure handling and checks

   task automatic abort_run();
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_word(input string name, input rb_word_t exp, input rb_word_t act);
      if (act !== exp) begin
         $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_leds(input string name, input led_t exp, input led_t act);
      if (act !== exp) begin
         $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_nib(input string name, input ctrl_nib_t exp, input ctrl_nib_t act);
      if (act !== exp) begin
         $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_clk_ctrl(input string name, input clk_ctrl_t exp, input clk_ctrl_t act);
      if (act !== exp) begin
         $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
         abort_run();
      end
   endtask

   // Watchdog, armed once the stimulus length is known
   initial begin : watchdog
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge dsp_clk);
      $display("Timeout, stimulus did not finish within %0d cycles", limit_cycles);
      abort_run();
   end

   ////////////////////////////////////////
   // Reference rules

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Time some number of ticks after the last load
   function automatic vita_time_t time_after(input int elapsed);
      longint   total;
      seconds_t secs;
      ticks_t   ticks;
      total = longint'(base_ticks) + longint'(elapsed);
      secs  = base_secs + seconds_t'(total / TB_TICKS);
      ticks = ticks_t'(total % TB_TICKS);
      return {secs, ticks};
   endfunction

   function automatic led_t expected_leds();
      led_t hw;
      led_t leds;
      int   b;
      hw    = '0;
      hw[4] = run_tx_i;
      hw[3] = run_rx_i;
      hw[2] = clk_status_i;
      hw[1] = serdes_link_up_i & good_sync;
      for (b = 0; b < 8; b++) begin
         leds[b] = led_src[b] ? hw[b] : led_sw[b];   // Source bit picks hardware
      end
      return leds;
   endfunction

   ////////////////////////////////////////
   // Bus and pin drivers

   task automatic next_cycle();
      @(posedge dsp_clk);
      #1;
   endtask

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      next_cycle();
      set_stb_i  = 1'b0;
      case (addr)
         SR_LED_SW:    led_sw    = data[7:0];
         SR_LED_SRC:   led_src   = data[7:0];
         SR_TIME_SECS: held_secs = data;
         SR_TIME_TICKS: begin
            base_secs  = held_secs;
            base_ticks = data;
            load_edge  = cycle_count;
         end
         default: ;
      endcase
   endtask

   task automatic set_status(input logic btn, input logic clk, input logic link,
                             input logic rx, input logic tx);
      button_i         = btn;
      clk_status_i     = clk;
      serdes_link_up_i = link;
      run_rx_i         = rx;
      run_tx_i         = tx;
      next_cycle();
   endtask

   task automatic read_word(input rb_addr_t idx, input string tok);
      rb_word_t   exp;
      vita_time_t now;
      exp       = '0;
      rb_addr_i = idx;
      next_cycle();
      now = time_after(cycle_count - 1 - load_edge);   // Value before the sampling edge
      if (tok == "compute") begin
         case (idx)
            RB_TIME_HI: exp = now[63:32];
            RB_TIME_LO: exp = now[31:0];
            RB_PPS_HI:  exp = pps_time[63:32];
            RB_PPS_LO:  exp = pps_time[31:0];
            default: begin
               $display("No rule to compute readback word %0d", idx);
               abort_run();
            end
         endcase
      end else begin
         void'($sscanf(tok, "%h", exp));
      end
      check_word($sformatf("rb_data_o[%0d]", idx), exp, rb_data_o);
   endtask

   // Sync delay is two edges, so the interrupt and latch are at fixed cycles
   task automatic pulse_pps();
      pps_i = 1'b1;
      next_cycle();
      check_bit("pps_int_o", 1'b0, pps_int_o);
      next_cycle();
      check_bit("pps_int_o", 1'b0, pps_int_o);
      pps_time = time_after(cycle_count - load_edge);
      pps_i    = 1'b0;
      next_cycle();
      check_bit("pps_int_o", 1'b1, pps_int_o);
      good_sync = 1'b1;
      next_cycle();
      check_bit("pps_int_o", 1'b0, pps_int_o);
   endtask

   task automatic random_leds(input int count);
      logic [31:0] rnd;
      repeat (count) begin
         rnd = next_random();
         write_setting(SR_LED_SW, {24'h0, rnd[31:24]});
         rnd = next_random();
         write_setting(SR_LED_SRC, {24'h0, rnd[31:24]});
         rnd = next_random();
         set_status(rnd[31], rnd[30], rnd[29], rnd[28], rnd[27]);
         check_leds("leds_o", expected_leds(), leds_o);
      end
   endtask

   // Line count and waits give the watchdog limit
   task automatic scan_length();
      int          fd;
      int          lines;
      int          waits;
      string       line;
      string       cmd;
      logic [31:0] arg0;
      lines = 0;
      waits = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file %s", STIM_FILE);
         abort_run();
      end
      while ($fgets(line, fd) != 0) begin
         cmd  = "";
         arg0 = '0;
         void'($sscanf(line, "%s %h", cmd, arg0));
         lines++;
         if (cmd == "wait")
            waits += int'(arg0);
         else if (cmd == "rand_leds")
            waits += 8 * int'(arg0);
      end
      $fclose(fd);
      limit_cycles = 64 * lines + waits + 16;
   endtask

   ////////////////////////////////////////
   // Main sequence

   initial begin : stimulus
      int          fd;
      string       line;
      string       cmd;
      string       tok;
      logic [31:0] arg0;
      logic [31:0] arg1;
      logic [31:0] arg2;
      logic [31:0] arg3;
      logic [31:0] arg4;
      por_rst    = 1'b1;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      rb_addr_i  = '0;
      pps_i      = 1'b0;
      button_i   = 1'b0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      run_rx_i   = 1'b0;
      run_tx_i   = 1'b0;
      held_secs  = '0;
      base_secs  = '0;
      base_ticks = '0;
      pps_time   = '0;
      led_sw     = '0;
      led_src    = LED_SRC_AT_RESET;
      good_sync  = 1'b0;
      scan_length();
      repeat (2) next_cycle();
      por_rst   = 1'b0;
      load_edge = cycle_count;   // Time counts up from zero here
      fd = $fopen(STIM_FILE, "r");
      while ($fgets(line, fd) != 0) begin
         cmd  = "";
         tok  = "";
         arg0 = '0;
         arg1 = '0;
         arg2 = '0;
         arg3 = '0;
         arg4 = '0;
         void'($sscanf(line, "%s %h %h %h %h %h", cmd, arg0, arg1, arg2, arg3, arg4));
         if (cmd == "" || cmd.getc(0) == "#") begin
            // Blank line or comment
         end else if (cmd == "wr") begin
            write_setting(set_addr_t'(arg0), arg1);
         end else if (cmd == "wait") begin
            repeat (arg0) next_cycle();
         end else if (cmd == "status") begin
            set_status(arg0[0], arg1[0], arg2[0], arg3[0], arg4[0]);
         end else if (cmd == "pps") begin
            pulse_pps();
         end else if (cmd == "rd") begin
            void'($sscanf(line, "%s %h %s", cmd, arg0, tok));
            read_word(rb_addr_t'(arg0), tok);
         end else if (cmd == "led") begin
            void'($sscanf(line, "%s %s", cmd, tok));
            if (tok == "compute") begin
               check_leds("leds_o", expected_leds(), leds_o);
            end else begin
               void'($sscanf(tok, "%h", arg0));
               check_leds("leds_o", led_t'(arg0), leds_o);
            end
         end else if (cmd == "ctrl") begin
            check_clk_ctrl("clock_ctrl_o", clk_ctrl_t'(arg0), clock_ctrl_o);
            check_nib("serdes_ctrl_o", ctrl_nib_t'(arg1), serdes_ctrl_o);
            check_nib("adc_ctrl_o", ctrl_nib_t'(arg2), adc_ctrl_o);
            check_bit("phy_reset_n_o", arg3[0], phy_reset_n_o);
         end else if (cmd == "rand_leds") begin
            random_leds(int'(arg0));
         end else begin
            $display("Unknown stimulus command %s", cmd);
            abort_run();
         end
      end
      $fclose(fd);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== hw/dsp_ctrl_core.sv ====
////////////////////////////////////////
// DSP clock control slice of the radio core
// Single clock domain, settings bus and status readback
// TICKS_PER_SEC must match the dsp_clk rate
////////////////////////////////////////

module dsp_ctrl_core
   import dsp_ctrl_pkg::*;
#(
   parameter ticks_t TICKS_PER_SEC = 32'd100_000_000
)(
   input  logic      dsp_clk,
   input  logic      por_rst,

   // Settings bus
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,

   // Status readback
   input  rb_addr_t  rb_addr_i,
   output rb_word_t  rb_data_o,

   input  logic      pps_i,
   output logic      pps_int_o,

   input  logic      clk_status_i,
   input  logic      button_i,
   input  logic      serdes_link_up_i,
   input  logic      run_rx_i,
   input  logic      run_tx_i,

   output led_t      leds_o,
   output clk_ctrl_t clock_ctrl_o,
   output ctrl_nib_t serdes_ctrl_o,
   output ctrl_nib_t adc_ctrl_o,
   output logic      phy_reset_n_o
);

   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       good_sync;
   rb_word_t   packed_ctrl;

   board_ctrl_regs board_ctrl_regs (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .good_sync_i(good_sync), .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .clock_ctrl_o(clock_ctrl_o), .serdes_ctrl_o(serdes_ctrl_o),
      .adc_ctrl_o(adc_ctrl_o), .phy_reset_n_o(phy_reset_n_o),
      .leds_o(leds_o), .packed_ctrl_o(packed_ctrl));

   ////////////////////////////////////////
   // VITA time

   vita_timekeeper #(.TICKS_PER_SEC(TICKS_PER_SEC)) vita_timekeeper (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .vita_time_o(vita_time));

   pps_capture pps_capture (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .pps_i(pps_i), .vita_time_i(vita_time),
      .vita_time_pps_o(vita_time_pps), .good_sync_o(good_sync),
      .pps_int_o(pps_int_o));

   ////////////////////////////////////////
   // Readback

   status_readback status_readback (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .rb_addr_i(rb_addr_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .packed_ctrl_i(packed_ctrl),
      .button_i(button_i), .clk_status_i(clk_status_i),
      .serdes_link_up_i(serdes_link_up_i),
      .rb_data_o(rb_data_o));

endmodule

// ==== hw/status_readback.sv ====
////////////////////////////////////////
// Status readback, 16 words
// Data follows rb_addr_i one cycle later
// Words 0 to 8 read as zero
////////////////////////////////////////

module status_readback
   import dsp_ctrl_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,

   input  rb_addr_t   rb_addr_i,

   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i,
   input  rb_word_t   packed_ctrl_i,
   input  logic       button_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,

   output rb_word_t   rb_data_o
);

   rb_word_t misc_status;

   // Bit positions kept from the legacy map
   assign misc_status = {18'b0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'b0};

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data_o <= '0;
      end else begin
         case (rb_addr_i)
            RB_PACKED_CTRL: rb_data_o <= packed_ctrl_i;
            RB_TIME_HI:     rb_data_o <= vita_time_i[63:32];
            RB_TIME_LO:     rb_data_o <= vita_time_i[31:0];
            RB_COMPAT:      rb_data_o <= COMPAT_NUM;
            RB_MISC_STATUS: rb_data_o <= misc_status;
            RB_PPS_HI:      rb_data_o <= vita_time_pps_i[63:32];
            RB_PPS_LO:      rb_data_o <= vita_time_pps_i[31:0];
            default:        rb_data_o <= '0;   // Dropped functions
         endcase
      end
   end

   // Note the time words are read separately, software reads HI then LO
   // and checks for a ticks wrap itself

endmodule

// ==== hw/vita_time/pps_capture.sv ====
////////////////////////////////////////
// PPS input capture on dsp_clk
// Two flop sync plus edge register, 2 cycle latency
// good_sync stays set until reset
////////////////////////////////////////

module pps_capture
   import dsp_ctrl_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,

   input  logic       pps_i,
   input  vita_time_t vita_time_i,

   output vita_time_t vita_time_pps_o,
   output logic       good_sync_o,
   output logic       pps_int_o
);

   logic pps_meta;
   logic pps_sync;
   logic pps_del;
   logic pps_edge;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_del  <= 1'b0;
      end else begin
         pps_meta <= pps_i;      // Async input
         pps_sync <= pps_meta;
         pps_del  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_del;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_int_o   <= 1'b0;
         good_sync_o <= 1'b0;
      end else begin
         pps_int_o <= pps_edge;   // One cycle per rising edge
         if (pps_edge)
            good_sync_o <= 1'b1;
      end
   end

   // Time at the capturing edge
   always_ff @(posedge dsp_clk) begin
      if (pps_edge)
         vita_time_pps_o <= vita_time_i;
   end

endmodule

// ==== hw/vita_time/vita_timekeeper.sv ====
////////////////////////////////////////
// Seconds and ticks counter, one tick per dsp_clk
// Seconds write is held, ticks write loads both at once
// Loaded ticks must be below TICKS_PER_SEC
////////////////////////////////////////

module vita_timekeeper
   import dsp_ctrl_pkg::*;
#(
   parameter ticks_t TICKS_PER_SEC = 32'd100_000_000
)(
   input  logic       dsp_clk,
   input  logic       por_rst,

   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,

   output vita_time_t vita_time_o
);

   localparam ticks_t LAST_TICK = TICKS_PER_SEC - 32'd1;

   seconds_t secs_held;   // Waits for the ticks write
   seconds_t secs;
   ticks_t   ticks;
   logic     load_secs;
   logic     load_time;

   assign load_secs = set_stb_i && (set_addr_i == SR_TIME_SECS);
   assign load_time = set_stb_i && (set_addr_i == SR_TIME_TICKS);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         secs_held <= '0;
      end else if (load_secs) begin
         secs_held <= set_data_i;
      end
   end

   ////////////////////////////////////////
   // Time counter

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         secs  <= '0;
         ticks <= '0;
      end else if (load_time) begin
         secs  <= secs_held;
         ticks <= set_data_i;
      end else if (ticks == LAST_TICK) begin
         secs  <= secs + 32'd1;   // Rolls into the next second
         ticks <= '0;
      end else begin
         ticks <= ticks + 32'd1;
      end
   end

   assign vita_time_o = {secs, ticks};

endmodule

// ==== hw/board_ctrl_regs.sv ====
////////////////////////////////////////
// Board control registers on the settings bus
// Only the low bits of each write are kept
// LED source bit 1 selects hardware, 0 selects software
////////////////////////////////////////

module board_ctrl_regs
   import dsp_ctrl_pkg::*;
(
   input  logic      dsp_clk,
   input  logic      por_rst,

   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,

   input  logic      clk_status_i,
   input  logic      serdes_link_up_i,
   input  logic      good_sync_i,
   input  logic      run_rx_i,
   input  logic      run_tx_i,

   output clk_ctrl_t clock_ctrl_o,
   output ctrl_nib_t serdes_ctrl_o,
   output ctrl_nib_t adc_ctrl_o,
   output logic      phy_reset_n_o,
   output led_t      leds_o,
   output rb_word_t  packed_ctrl_o
);

   clk_ctrl_t clk_ctrl;
   ctrl_nib_t ser_ctrl;
   ctrl_nib_t adc_ctrl;
   led_t      led_sw;
   led_t      led_src;
   logic      phy_reset;     // Active high, pin is inverted
   led_t      led_hw;

   ////////////////////////////////////////
   // Setting registers

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clk_ctrl  <= '0;
         ser_ctrl  <= '0;
         adc_ctrl  <= '0;
         led_sw    <= '0;
         phy_reset <= 1'b0;
         led_src   <= LED_SRC_AT_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_CLK_CTRL: clk_ctrl  <= set_data_i[4:0];
            SR_SER_CTRL: ser_ctrl  <= set_data_i[3:0];
            SR_ADC_CTRL: adc_ctrl  <= set_data_i[3:0];
            SR_LED_SW:   led_sw    <= set_data_i[7:0];
            SR_PHY_RST:  phy_reset <= set_data_i[0];
            SR_LED_SRC:  led_src   <= set_data_i[7:0];
            default: ;   // Other blocks or unused slots
         endcase
      end
   end

   assign clock_ctrl_o  = clk_ctrl;
   assign serdes_ctrl_o = ser_ctrl;
   assign adc_ctrl_o    = adc_ctrl;
   assign phy_reset_n_o = ~phy_reset;

   ////////////////////////////////////////
   // LED source select

   // Link LED only once PPS has locked the time
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   // Readback image of the control state
   assign packed_ctrl_o = {led_src, led_sw, 4'h0, adc_ctrl, 4'h0, ser_ctrl};

endmodule

// ==== common/dsp_ctrl_pkg.sv ====
////////////////////////////////////////
// Types and constants shared by the DSP control slice
// The same settings addresses decode in every instance
// Readback indices follow the legacy 16-word status map
////////////////////////////////////////

package dsp_ctrl_pkg;

   // Bus and field widths
   typedef logic [7:0]  set_addr_t;   // Settings register address
   typedef logic [31:0] set_data_t;   // Settings write data
   typedef logic [3:0]  rb_addr_t;    // Readback word index
   typedef logic [31:0] rb_word_t;    // Readback word
   typedef logic [31:0] seconds_t;
   typedef logic [31:0] ticks_t;
   typedef logic [63:0] vita_time_t;  // Seconds in [63:32], ticks in [31:0]
   typedef logic [7:0]  led_t;
   typedef logic [3:0]  ctrl_nib_t;   // SERDES or ADC control group
   typedef logic [4:0]  clk_ctrl_t;   // Clock generator control

   ////////////////////////////////////////
   // Settings bus map

   localparam set_addr_t SR_MISC   = 8'd0;    // Offset 5 of this block is unused
   localparam set_addr_t SR_TIME64 = 8'd10;

   localparam set_addr_t SR_CLK_CTRL = SR_MISC + 8'd0;
   localparam set_addr_t SR_SER_CTRL = SR_MISC + 8'd1;
   localparam set_addr_t SR_ADC_CTRL = SR_MISC + 8'd2;
   localparam set_addr_t SR_LED_SW   = SR_MISC + 8'd3;
   localparam set_addr_t SR_PHY_RST  = SR_MISC + 8'd4;
   localparam set_addr_t SR_LED_SRC  = SR_MISC + 8'd6;

   localparam set_addr_t SR_TIME_SECS  = SR_TIME64 + 8'd0;
   localparam set_addr_t SR_TIME_TICKS = SR_TIME64 + 8'd1;  // Loads the time

   ////////////////////////////////////////
   // Readback word indices

   localparam rb_addr_t RB_PACKED_CTRL = 4'd9;
   localparam rb_addr_t RB_TIME_HI     = 4'd10;
   localparam rb_addr_t RB_TIME_LO     = 4'd11;
   localparam rb_addr_t RB_COMPAT      = 4'd12;
   localparam rb_addr_t RB_MISC_STATUS = 4'd13;
   localparam rb_addr_t RB_PPS_HI      = 4'd14;
   localparam rb_addr_t RB_PPS_LO      = 4'd15;

   // Bump major when software must change, minor otherwise
   localparam rb_word_t COMPAT_NUM = {16'd8, 16'd2};

   // LEDs 1 to 4 follow hardware after reset
   localparam led_t LED_SRC_AT_RESET = 8'h1E;

endpackage
